// File: src.f
+incdir+logic
+incdir+sim
logic/tracePkg.sv
logic/rvfiCapture.sv
logic/csrMerge.sv
logic/gprDecode.sv
logic/netMonitor.sv
logic/traceBridge.sv
sim/traceBridge_chk.sv
sim/traceBridgeTb.sv

// File: Bender.yml
package:
  name: trace_bridge

sources:
  - include_dirs:
      - logic
    files:
      - logic/tracePkg.sv
      - logic/rvfiCapture.sv
      - logic/csrMerge.sv
      - logic/gprDecode.sv
      - logic/netMonitor.sv
      - logic/traceBridge.sv
  - target: simulation
    include_dirs:
      - logic
      - sim
    files:
      - sim/traceBridge_chk.sv
      - sim/traceBridgeTb.sv

// File: sim/traceBridgeTests.svh
// Wait helpers, retirement drivers and the directed tests
`ifndef TRACE_BRIDGE_TESTS_SVH
`define TRACE_BRIDGE_TESTS_SVH

////////////////////
// Helpers
////////////////////

// Outputs sampled on the falling edge, away from the driving edge
task automatic awaitValid();
    int n = 0;
    @(negedge rvvi);
    while (valid !== 1'b1) begin
        n++;
        if (n > TIMEOUT) begin
            $display("Timed out waiting for valid_o");
            stopRun();
        end
        @(negedge rvvi);
    end
endtask

task automatic awaitNet();
    int n = 0;
    @(negedge rvvi);
    while (netValid !== 1'b1) begin
        n++;
        if (n > TIMEOUT) begin
            $display("Timed out waiting for netValid_o");
            stopRun();
        end
        @(negedge rvvi);
    end
endtask

// Callers may add more NBAs in the same time step
task automatic startRetire(input logic [`ORDER_W-1:0] ord, input logic [`XLEN-1:0] ins, pcV,
                           input logic tr, it);
    @(posedge rvvi);
    rvfiValid <= 1'b1;
    rvfiOrder <= ord;
    rvfiInsn  <= ins;
    rvfiPc    <= pcV;
    rvfiTrap  <= tr;
    rvfiIntr  <= it;
endtask

task automatic stopRetire();
    @(posedge rvvi);
    rvfiValid <= 1'b0;
endtask

// Each bit from the write data where its mask bit is set, else from the read data
function automatic logic [`XLEN-1:0] applyCsrMask(input logic [`XLEN-1:0] w, m, r);
    logic [`XLEN-1:0] v;
    for (int b = 0; b < `XLEN; b++) begin
        v[b] = m[b] ? w[b] : r[b];
    end
    return v;
endfunction

function automatic logic [NUM_CSR-1:0] changedSlots(input logic [NUM_CSR-1:0][`XLEN-1:0] v);
    logic [NUM_CSR-1:0] f;
    for (int i = 0; i < NUM_CSR; i++) begin
        f[i] = (v[i] != csrLast[i]);
    end
    return f;
endfunction

////////////////////
// Tests
////////////////////

task automatic testIdle();
    repeat (TIMEOUT) begin
        @(negedge rvvi);
        if (valid !== 1'b0 || csrWb !== '0 || xWb !== '0 || netValid !== 1'b0) begin
            $display("Output activity seen with idle inputs after reset");
            stopRun();
        end
    end
endtask

task automatic testSingle();
    logic [`ORDER_W-1:0] ord = 64'h0000_0001_0000_0042;
    logic [`XLEN-1:0]    ins = 32'h0030_0093;
    logic [`XLEN-1:0]    pcV = 32'h8000_0100;
    startRetire(ord, ins, pcV, 1'b1, 1'b1);
    stopRetire();
    awaitValid();
    checkRetire(ord, ins, pcV, 1'b1, 1'b1);
endtask

task automatic testCsr();
    logic [NUM_CSR-1:0][`XLEN-1:0] w, m, r, expVal;
    logic [NUM_CSR-1:0]            expWb;
    for (int i = 0; i < NUM_CSR; i++) begin
        w[i] = $random(seed);
        m[i] = $random(seed);
        r[i] = $random(seed);
        expVal[i] = applyCsrMask(w[i], m[i], r[i]);
    end
    // Random merge, flags against the model shadow
    startRetire(64'h10, 32'h3000_2073, 32'h400, 1'b0, 1'b0);
    rvfiCsrWdata <= w;
    rvfiCsrWmask <= m;
    rvfiCsrRdata <= r;
    stopRetire();
    awaitValid();
    checkCsr(expVal, changedSlots(expVal));
    // Same values again
    startRetire(64'h11, 32'h3000_2073, 32'h404, 1'b0, 1'b0);
    stopRetire();
    awaitValid();
    checkCsr(expVal, '0);
    // mepc fully written with new data, others untouched
    m[Mepc] = '1;
    w[Mepc] = ~expVal[Mepc];
    expVal[Mepc] = w[Mepc];
    expWb = '0;
    expWb[Mepc] = 1'b1;
    startRetire(64'h12, 32'h3410_1073, 32'h408, 1'b0, 1'b0);
    rvfiCsrWdata <= w;
    rvfiCsrWmask <= m;
    stopRetire();
    awaitValid();
    checkCsr(expVal, expWb);
endtask

task automatic testGpr();
    logic [`XLEN-1:0]                d0 = $random(seed);
    logic [`XLEN-1:0]                d1 = $random(seed);
    logic [`NUM_REGS-1:0]            expWb = '0;
    logic [`NUM_REGS-1:0][`XLEN-1:0] expData = '0;
    // Port 0 to x5, port 1 to x9
    startRetire(64'h20, 32'h00b5_0533, 32'h500, 1'b0, 1'b0);
    rvfiRdAddr  <= {5'd9, 5'd5};
    rvfiRdWdata <= {d1, d0};
    stopRetire();
    awaitValid();
    expWb[5] = 1'b1;
    expData[5] = d0;
    expWb[9] = 1'b1;
    expData[9] = d1;
    checkGpr(expWb, expData);
    // Both ports on x12
    startRetire(64'h21, 32'h00b5_0633, 32'h504, 1'b0, 1'b0);
    rvfiRdAddr <= {5'd12, 5'd12};
    stopRetire();
    awaitValid();
    expWb = '0;
    expData = '0;
    expWb[12] = 1'b1;
    expData[12] = d1;
    checkGpr(expWb, expData);
    // x0 on both ports
    startRetire(64'h22, 32'h0000_0013, 32'h508, 1'b0, 1'b0);
    rvfiRdAddr <= '0;
    stopRetire();
    awaitValid();
    checkGpr('0, '0);
endtask

// CSR and rd inputs held, so no CSR flags are expected
task automatic testStream();
    logic [`XLEN-1:0] insnQ [6];
    fork
        begin
            for (int i = 0; i < 6; i++) begin
                insnQ[i] = $random(seed);
                startRetire(64'h100 + i, insnQ[i], 32'h2000 + 4 * i, 1'b0, i[0]);
            end
            stopRetire();
        end
        begin
            awaitValid();
            for (int i = 0; i < 6; i++) begin
                if (valid !== 1'b1) begin
                    $display("Gap in the retirement stream at beat %0d", i);
                    stopRun();
                end
                checkRetire(64'h100 + i, insnQ[i], 32'h2000 + 4 * i, 1'b0, i[0]);
                checkCsr(csrLast, '0);
                @(negedge rvvi);
            end
            if (valid !== 1'b0) begin
                $display("Extra retirement after the stream");
                stopRun();
            end
        end
    join
endtask

task automatic testNet();
    // Timer line alone
    @(posedge rvvi);
    irq[NET_IRQ_BIT[MTimerIrq]] <= 1'b1;
    awaitNet();
    checkNet(MTimerIrq, 1'b1);
    @(negedge rvvi);
    if (netValid !== 1'b0) begin
        $display("Net event repeated for a single change");
        stopRun();
    end
    // Three nets at once, reported in id order
    @(posedge rvvi);
    irq[NET_IRQ_BIT[MSwIrq]] <= 1'b1;
    irq[NET_IRQ_BIT[Local0]] <= 1'b1;
    debugReq <= 1'b1;
    awaitNet();
    checkNet(MSwIrq, 1'b1);
    @(negedge rvvi);
    checkNet(Local0, 1'b1);
    @(negedge rvvi);
    checkNet(HaltReq, 1'b1);
endtask

`endif

// File: sim/traceBridgeTb.sv
// Testbench top with clock, reset, DUT, compare tasks and the test sequence
`timescale 1ns/1ps
`include "traceBridge_settings.svh"

module traceBridgeTb;

    import tracePkg::*;

    // Cycles any single wait may take
    localparam int TIMEOUT = 20;

    logic rvvi;
    logic rstN;

    ////////////////////
    // DUT signals
    ////////////////////

    logic                                rvfiValid;
    logic [`ORDER_W-1:0]                 rvfiOrder;
    logic [`XLEN-1:0]                    rvfiInsn;
    logic [`XLEN-1:0]                    rvfiPc;
    logic                                rvfiTrap;
    logic                                rvfiIntr;
    logic [`NUM_RD-1:0][`REG_ADDR_W-1:0] rvfiRdAddr;
    logic [`NUM_RD-1:0][`XLEN-1:0]       rvfiRdWdata;
    logic [NUM_CSR-1:0][`XLEN-1:0]       rvfiCsrWdata;
    logic [NUM_CSR-1:0][`XLEN-1:0]       rvfiCsrWmask;
    logic [NUM_CSR-1:0][`XLEN-1:0]       rvfiCsrRdata;
    logic [`NUM_IRQ-1:0]                 irq;
    logic                                debugReq;
    logic                                valid;
    logic [`ORDER_W-1:0]                 order;
    logic [`XLEN-1:0]                    insn;
    logic [`XLEN-1:0]                    pc;
    logic                                trap;
    logic                                intr;
    logic [`NUM_REGS-1:0]                xWb;
    logic [`NUM_REGS-1:0][`XLEN-1:0]     xWdata;
    logic [NUM_CSR-1:0][`XLEN-1:0]       csrValue;
    logic [NUM_CSR-1:0]                  csrWb;
    logic                                netValid;
    netId_e                              netId;
    logic                                netLevel;

    // Last CSR values seen by the checker side, the model shadow
    logic [NUM_CSR-1:0][`XLEN-1:0] csrLast;
    int seed = 54;

    initial begin
        rvvi = 1'b0;
        forever #20 rvvi = ~rvvi;
    end

    traceBridge DUT (
        .rvvi(rvvi), .rstN_i(rstN),
        .rvfiValid_i(rvfiValid), .rvfiOrder_i(rvfiOrder), .rvfiInsn_i(rvfiInsn),
        .rvfiPc_i(rvfiPc), .rvfiTrap_i(rvfiTrap), .rvfiIntr_i(rvfiIntr),
        .rvfiRdAddr_i(rvfiRdAddr), .rvfiRdWdata_i(rvfiRdWdata),
        .rvfiCsrWdata_i(rvfiCsrWdata), .rvfiCsrWmask_i(rvfiCsrWmask),
        .rvfiCsrRdata_i(rvfiCsrRdata), .irq_i(irq), .debugReq_i(debugReq),
        .valid_o(valid), .order_o(order), .insn_o(insn), .pc_o(pc),
        .trap_o(trap), .intr_o(intr), .xWb_o(xWb), .xWdata_o(xWdata),
        .csrValue_o(csrValue), .csrWb_o(csrWb),
        .netValid_o(netValid), .netId_o(netId), .netLevel_o(netLevel)
    );

    bind traceBridge traceBridge_chk uChk (
        .rvvi        (rvvi),
        .rstN_i      (rstN_i),
        .rvfiValid_i (rvfiValid_i),
        .valid_i     (valid_o),
        .xWb_i       (xWb_o),
        .netValid_i  (netValid_o)
    );

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic stopRun();
        $display("Test failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic showMismatch(input string name, input logic [1023:0] got, expVal);
        $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, expVal);
        stopRun();
    endtask

    task automatic checkRetire(input logic [`ORDER_W-1:0] expOrder,
                               input logic [`XLEN-1:0] expInsn, expPc,
                               input logic expTrap, expIntr);
        if (order !== expOrder)
            showMismatch("order_o", order, expOrder);
        if (insn !== expInsn)
            showMismatch("insn_o", insn, expInsn);
        if (pc !== expPc)
            showMismatch("pc_o", pc, expPc);
        if ({trap, intr} !== {expTrap, expIntr})
            showMismatch("trap_o,intr_o", {trap, intr}, {expTrap, expIntr});
    endtask

    // Reported values become the reference for later change flags
    task automatic checkCsr(input logic [NUM_CSR-1:0][`XLEN-1:0] expVal,
                            input logic [NUM_CSR-1:0] expWb);
        if (csrValue !== expVal)
            showMismatch("csrValue_o", csrValue, expVal);
        if (csrWb !== expWb)
            showMismatch("csrWb_o", csrWb, expWb);
        csrLast = expVal;
    endtask

    task automatic checkGpr(input logic [`NUM_REGS-1:0] expWb,
                            input logic [`NUM_REGS-1:0][`XLEN-1:0] expData);
        if (xWb !== expWb)
            showMismatch("xWb_o", xWb, expWb);
        if (xWdata !== expData)
            showMismatch("xWdata_o", xWdata, expData);
    endtask

    task automatic checkNet(input netId_e expId, input logic expLevel);
        if (netValid !== 1'b1) begin
            $display("Expected a net event but netValid_o is low");
            stopRun();
        end
        if (netId !== expId)
            showMismatch("netId_o", netId, expId);
        if (netLevel !== expLevel)
            showMismatch("netLevel_o", netLevel, expLevel);
    endtask

    `include "traceBridgeTests.svh"

    ////////////////////
    // Sequence
    ////////////////////

    initial begin
        rstN = 1'b0;
        rvfiValid = 1'b0;
        rvfiOrder = '0;
        rvfiInsn = '0;
        rvfiPc = '0;
        rvfiTrap = 1'b0;
        rvfiIntr = 1'b0;
        rvfiRdAddr = '0;
        rvfiRdWdata = '0;
        rvfiCsrWdata = '0;
        rvfiCsrWmask = '0;
        rvfiCsrRdata = '0;
        irq = '0;
        debugReq = 1'b0;
        csrLast = '0;
        repeat (5) @(posedge rvvi);
        rstN <= 1'b1;
        testIdle();
        testSingle();
        testCsr();
        testGpr();
        testStream();
        testNet();
        repeat (3) @(posedge rvvi);
        if (DUT.uChk.failCount == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "Assertion failures in the bound checker");
        end
    end

endmodule

// File: sim/traceBridge_chk.sv
// Bound assertions on pipeline latency, x0 write-back and net events in reset
`timescale 1ns/1ps
`include "traceBridge_settings.svh"

module traceBridge_chk (
    input logic                 rvvi,
    input logic                 rstN_i,
    input logic                 rvfiValid_i,
    input logic                 valid_i,
    input logic [`NUM_REGS-1:0] xWb_i,
    input logic                 netValid_i
);

    // Failed assertions so far
    int failCount = 0;

    // Two-stage latency, no drops and no extra beats
    assert property (@(posedge rvvi) disable iff (!rstN_i)
        valid_i == $past(rvfiValid_i, 2))
    else begin
        $error("valid_o does not follow rvfiValid_i by two cycles");
        failCount++;
    end

    // x0 is never a write target
    assert property (@(posedge rvvi) disable iff (!rstN_i) !xWb_i[0])
    else begin
        $error("xWb_o bit 0 set");
        failCount++;
    end

    // Monitor silent while reset is held
    assert property (@(posedge rvvi) !rstN_i |=> !netValid_i)
    else begin
        $error("netValid_o high during reset");
        failCount++;
    end

endmodule

// File: logic/traceBridge.sv
// Top level of the RVFI to RVVI trace bridge
`timescale 1ns/1ps
`include "traceBridge_settings.svh"

module traceBridge (
    input  logic                                      rvvi,
    input  logic                                      rstN_i,
    // RVFI retirement
    input  logic                                      rvfiValid_i,
    input  logic [`ORDER_W-1:0]                       rvfiOrder_i,
    input  logic [`XLEN-1:0]                          rvfiInsn_i,
    input  logic [`XLEN-1:0]                          rvfiPc_i,
    input  logic                                      rvfiTrap_i,
    input  logic                                      rvfiIntr_i,
    input  logic [`NUM_RD-1:0][`REG_ADDR_W-1:0]       rvfiRdAddr_i,
    input  logic [`NUM_RD-1:0][`XLEN-1:0]             rvfiRdWdata_i,
    input  logic [tracePkg::NUM_CSR-1:0][`XLEN-1:0]   rvfiCsrWdata_i,
    input  logic [tracePkg::NUM_CSR-1:0][`XLEN-1:0]   rvfiCsrWmask_i,
    input  logic [tracePkg::NUM_CSR-1:0][`XLEN-1:0]   rvfiCsrRdata_i,
    // Watched nets
    input  logic [`NUM_IRQ-1:0]                       irq_i,
    input  logic                                      debugReq_i,
    // RVVI retirement
    output logic                                      valid_o,
    output logic [`ORDER_W-1:0]                       order_o,
    output logic [`XLEN-1:0]                          insn_o,
    output logic [`XLEN-1:0]                          pc_o,
    output logic                                      trap_o,
    output logic                                      intr_o,
    output logic [`NUM_REGS-1:0]                      xWb_o,
    output logic [`NUM_REGS-1:0][`XLEN-1:0]           xWdata_o,
    output logic [tracePkg::NUM_CSR-1:0][`XLEN-1:0]   csrValue_o,
    output logic [tracePkg::NUM_CSR-1:0]              csrWb_o,
    // RVVI net events
    output logic                                      netValid_o,
    output tracePkg::netId_e                          netId_o,
    output logic                                      netLevel_o
);

    import tracePkg::*;

    ////////////////////
    // Stage 1
    ////////////////////

    logic                                s1Valid;
    logic [`ORDER_W-1:0]                 s1Order;
    logic [`XLEN-1:0]                    s1Insn;
    logic [`XLEN-1:0]                    s1Pc;
    logic                                s1Trap;
    logic                                s1Intr;
    logic [`NUM_RD-1:0][`REG_ADDR_W-1:0] s1RdAddr;
    logic [`NUM_RD-1:0][`XLEN-1:0]       s1RdWdata;
    logic [NUM_CSR-1:0][`XLEN-1:0]       s1CsrWdata;
    logic [NUM_CSR-1:0][`XLEN-1:0]       s1CsrWmask;
    logic [NUM_CSR-1:0][`XLEN-1:0]       s1CsrRdata;

    rvfiCapture uCapture (
        .rvvi           (rvvi),
        .rstN_i         (rstN_i),
        .rvfiValid_i    (rvfiValid_i),
        .rvfiOrder_i    (rvfiOrder_i),
        .rvfiInsn_i     (rvfiInsn_i),
        .rvfiPc_i       (rvfiPc_i),
        .rvfiTrap_i     (rvfiTrap_i),
        .rvfiIntr_i     (rvfiIntr_i),
        .rvfiRdAddr_i   (rvfiRdAddr_i),
        .rvfiRdWdata_i  (rvfiRdWdata_i),
        .rvfiCsrWdata_i (rvfiCsrWdata_i),
        .rvfiCsrWmask_i (rvfiCsrWmask_i),
        .rvfiCsrRdata_i (rvfiCsrRdata_i),
        .s1Valid_o      (s1Valid),
        .s1Order_o      (s1Order),
        .s1Insn_o       (s1Insn),
        .s1Pc_o         (s1Pc),
        .s1Trap_o       (s1Trap),
        .s1Intr_o       (s1Intr),
        .s1RdAddr_o     (s1RdAddr),
        .s1RdWdata_o    (s1RdWdata),
        .s1CsrWdata_o   (s1CsrWdata),
        .s1CsrWmask_o   (s1CsrWmask),
        .s1CsrRdata_o   (s1CsrRdata)
    );

    ////////////////////
    // Stage 2
    ////////////////////

    // CSR merge also owns valid_o
    csrMerge uCsrMerge (
        .rvvi         (rvvi),
        .rstN_i       (rstN_i),
        .s1Valid_i    (s1Valid),
        .s1CsrWdata_i (s1CsrWdata),
        .s1CsrWmask_i (s1CsrWmask),
        .s1CsrRdata_i (s1CsrRdata),
        .valid_o      (valid_o),
        .csrValue_o   (csrValue_o),
        .csrWb_o      (csrWb_o)
    );

    gprDecode uGprDecode (
        .rvvi        (rvvi),
        .rstN_i      (rstN_i),
        .s1Valid_i   (s1Valid),
        .s1RdAddr_i  (s1RdAddr),
        .s1RdWdata_i (s1RdWdata),
        .xWb_o       (xWb_o),
        .xWdata_o    (xWdata_o)
    );

    // Retirement fields move with valid_o, hold when idle
    always_ff @(posedge rvvi) begin
        if (s1Valid) begin
            order_o <= s1Order;
            insn_o  <= s1Insn;
            pc_o    <= s1Pc;
            trap_o  <= s1Trap;
            intr_o  <= s1Intr;
        end
    end

    ////////////////////
    // Net events
    ////////////////////

    // Independent of the retirement pipeline
    netMonitor uNetMonitor (
        .rvvi       (rvvi),
        .rstN_i     (rstN_i),
        .irq_i      (irq_i),
        .debugReq_i (debugReq_i),
        .netValid_o (netValid_o),
        .netId_o    (netId_o),
        .netLevel_o (netLevel_o)
    );

endmodule

// File: logic/netMonitor.sv
// Serializer of interrupt and halt-request change events
`timescale 1ns/1ps
`include "traceBridge_settings.svh"

module netMonitor (
    input  logic                  rvvi,
    input  logic                  rstN_i,
    input  logic [`NUM_IRQ-1:0]   irq_i,
    input  logic                  debugReq_i,
    output logic                  netValid_o,
    output tracePkg::netId_e      netId_o,
    output logic                  netLevel_o
);

    import tracePkg::*;

    // Current level of each watched net, indexed by netId_e
    logic [NUM_NET-1:0] levelD;
    // Last level reported per net
    logic [NUM_NET-1:0] shadowQ;
    logic [NUM_NET-1:0] diffD;
    netId_e             pickD;
    logic               foundD;

    ////////////////////
    // Gather levels
    ////////////////////

    always_comb begin
        for (int i = 0; i < NUM_IRQ_NET; i++) begin
            levelD[i] = irq_i[NET_IRQ_BIT[i]];
        end
        levelD[HaltReq] = debugReq_i;
    end

    assign diffD = levelD ^ shadowQ;

    // Lowest differing net goes first
    always_comb begin
        pickD  = MSwIrq;
        foundD = 1'b0;
        for (int i = 0; i < NUM_NET; i++) begin
            if (diffD[i] && !foundD) begin
                pickD  = netId_e'(i);
                foundD = 1'b1;
            end
        end
    end

    ////////////////////
    // Event register
    ////////////////////

    // Only the reported net catches up, the rest wait their turn
    always_ff @(posedge rvvi) begin
        if (!rstN_i) begin
            shadowQ    <= '0;
            netValid_o <= 1'b0;
        end else begin
            netValid_o <= foundD;
            if (foundD) begin
                shadowQ[pickD] <= levelD[pickD];
            end
        end
    end

    always_ff @(posedge rvvi) begin
        netId_o    <= pickD;
        netLevel_o <= levelD[pickD];
    end

endmodule

// File: logic/gprDecode.sv
// Stage 2 decode of destination-register writes into the register-wide view
`timescale 1ns/1ps
`include "traceBridge_settings.svh"

module gprDecode (
    input  logic                                  rvvi,
    input  logic                                  rstN_i,
    input  logic                                  s1Valid_i,
    input  logic [`NUM_RD-1:0][`REG_ADDR_W-1:0]   s1RdAddr_i,
    input  logic [`NUM_RD-1:0][`XLEN-1:0]         s1RdWdata_i,
    output logic [`NUM_REGS-1:0]                  xWb_o,
    output logic [`NUM_REGS-1:0][`XLEN-1:0]       xWdata_o
);

    logic [`NUM_REGS-1:0]            wbD;
    logic [`NUM_REGS-1:0][`XLEN-1:0] dataD;

    ////////////////////
    // Port decode
    ////////////////////

    // Later ports override earlier ones, so port 1 wins a tie
    // x0 is never reported
    always_comb begin
        wbD   = '0;
        dataD = '0;
        for (int p = 0; p < `NUM_RD; p++) begin
            if (s1RdAddr_i[p] != '0) begin
                wbD[s1RdAddr_i[p]]   = 1'b1;
                dataD[s1RdAddr_i[p]] = s1RdWdata_i[p];
            end
        end
    end

    ////////////////////
    // Stage 2 register
    ////////////////////

    // Mask clears on idle cycles
    always_ff @(posedge rvvi) begin
        if (!rstN_i) begin
            xWb_o <= '0;
        end else begin
            xWb_o <= s1Valid_i ? wbD : '0;
        end
    end

    // Data zeroed alongside the mask
    always_ff @(posedge rvvi) begin
        xWdata_o <= s1Valid_i ? dataD : '0;
    end

endmodule

// File: logic/csrMerge.sv
// Stage 2 CSR value merge, change flags and the pipeline valid register
`timescale 1ns/1ps
`include "traceBridge_settings.svh"

module csrMerge (
    input  logic                                      rvvi,
    input  logic                                      rstN_i,
    input  logic                                      s1Valid_i,
    input  logic [tracePkg::NUM_CSR-1:0][`XLEN-1:0]   s1CsrWdata_i,
    input  logic [tracePkg::NUM_CSR-1:0][`XLEN-1:0]   s1CsrWmask_i,
    input  logic [tracePkg::NUM_CSR-1:0][`XLEN-1:0]   s1CsrRdata_i,
    output logic                                      valid_o,
    output logic [tracePkg::NUM_CSR-1:0][`XLEN-1:0]   csrValue_o,
    output logic [tracePkg::NUM_CSR-1:0]              csrWb_o
);

    import tracePkg::*;

    // Merged value per slot, before the register
    logic [NUM_CSR-1:0][`XLEN-1:0] mergedD;
    // Slots whose merged value moved away from the last report
    logic [NUM_CSR-1:0]            changedD;

    ////////////////////
    // Mask rule
    ////////////////////

    // Write data under the mask, read data elsewhere
    always_comb begin
        for (int i = 0; i < NUM_CSR; i++) begin
            mergedD[i] = (s1CsrWdata_i[i] & s1CsrWmask_i[i])
                       | (s1CsrRdata_i[i] & ~s1CsrWmask_i[i]);
        end
    end

    // Compare against what the checker last saw
    // csrValue_o holds that value between retirements
    always_comb begin
        for (int i = 0; i < NUM_CSR; i++) begin
            changedD[i] = (mergedD[i] != csrValue_o[i]);
        end
    end

    ////////////////////
    // Stage 2 register
    ////////////////////

    // Valid for the whole stage 2
    always_ff @(posedge rvvi) begin
        if (!rstN_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= s1Valid_i;
        end
    end

    // Reported values double as the shadow copies
    // Write-back flags only live for one output cycle
    always_ff @(posedge rvvi) begin
        if (!rstN_i) begin
            csrValue_o <= '0;
            csrWb_o    <= '0;
        end else if (s1Valid_i) begin
            csrValue_o <= mergedD;
            csrWb_o    <= changedD;
        end else begin
            csrWb_o    <= '0;
        end
    end

endmodule

// File: logic/rvfiCapture.sv
// Stage 1 register of the RVFI retirement fields
`timescale 1ns/1ps
`include "traceBridge_settings.svh"

module rvfiCapture (
    input  logic                                      rvvi,
    input  logic                                      rstN_i,
    // Retirement trace in
    input  logic                                      rvfiValid_i,
    input  logic [`ORDER_W-1:0]                       rvfiOrder_i,
    input  logic [`XLEN-1:0]                          rvfiInsn_i,
    input  logic [`XLEN-1:0]                          rvfiPc_i,
    input  logic                                      rvfiTrap_i,
    input  logic                                      rvfiIntr_i,
    input  logic [`NUM_RD-1:0][`REG_ADDR_W-1:0]       rvfiRdAddr_i,
    input  logic [`NUM_RD-1:0][`XLEN-1:0]             rvfiRdWdata_i,
    input  logic [tracePkg::NUM_CSR-1:0][`XLEN-1:0]   rvfiCsrWdata_i,
    input  logic [tracePkg::NUM_CSR-1:0][`XLEN-1:0]   rvfiCsrWmask_i,
    input  logic [tracePkg::NUM_CSR-1:0][`XLEN-1:0]   rvfiCsrRdata_i,
    // Stage 1 out
    output logic                                      s1Valid_o,
    output logic [`ORDER_W-1:0]                       s1Order_o,
    output logic [`XLEN-1:0]                          s1Insn_o,
    output logic [`XLEN-1:0]                          s1Pc_o,
    output logic                                      s1Trap_o,
    output logic                                      s1Intr_o,
    output logic [`NUM_RD-1:0][`REG_ADDR_W-1:0]       s1RdAddr_o,
    output logic [`NUM_RD-1:0][`XLEN-1:0]             s1RdWdata_o,
    output logic [tracePkg::NUM_CSR-1:0][`XLEN-1:0]   s1CsrWdata_o,
    output logic [tracePkg::NUM_CSR-1:0][`XLEN-1:0]   s1CsrWmask_o,
    output logic [tracePkg::NUM_CSR-1:0][`XLEN-1:0]   s1CsrRdata_o
);

    ////////////////////
    // Valid flag
    ////////////////////

    // One pulse per retirement, no back-pressure
    always_ff @(posedge rvvi) begin
        if (!rstN_i) begin
            s1Valid_o <= 1'b0;
        end else begin
            s1Valid_o <= rvfiValid_i;
        end
    end

    ////////////////////
    // Payload
    ////////////////////

    // Loaded on valid only
    // Idle cycles keep the last retirement
    always_ff @(posedge rvvi) begin
        if (rvfiValid_i) begin
            s1Order_o    <= rvfiOrder_i;
            s1Insn_o     <= rvfiInsn_i;
            s1Pc_o       <= rvfiPc_i;
            s1Trap_o     <= rvfiTrap_i;
            s1Intr_o     <= rvfiIntr_i;
            s1RdAddr_o   <= rvfiRdAddr_i;
            s1RdWdata_o  <= rvfiRdWdata_i;
            s1CsrWdata_o <= rvfiCsrWdata_i;
            s1CsrWmask_o <= rvfiCsrWmask_i;
            s1CsrRdata_o <= rvfiCsrRdata_i;
        end
    end

endmodule

// File: logic/tracePkg.sv
// Package with CSR slot enum, net identifier enum and the irq line map
package tracePkg;

    ////////////////////
    // CSR slots
    ////////////////////

    // Machine CSRs forwarded to the checker, one slot each
    typedef enum logic [2:0] {
        Mstatus,
        Mie,
        Mtvec,
        Mscratch,
        Mepc,
        Mcause
    } csrSel_e;

    // Slot count follows the enum
    localparam int NUM_CSR = int'(Mcause) + 1;

    ////////////////////
    // Watched nets
    ////////////////////

    // Event order is priority order, lowest first
    typedef enum logic [4:0] {
        MSwIrq, MTimerIrq, MExtIrq,
        Local0, Local1, Local2, Local3, Local4, Local5, Local6, Local7,
        Local8, Local9, Local10, Local11, Local12, Local13, Local14, Local15,
        HaltReq
    } netId_e;

    localparam int NUM_NET = int'(HaltReq) + 1;

    // Interrupt nets sit below HaltReq
    localparam int NUM_IRQ_NET = int'(HaltReq);

    // irq bus bit for each interrupt net
    localparam int NET_IRQ_BIT [NUM_IRQ_NET] = '{
        3, 7, 11,
        16, 17, 18, 19, 20, 21, 22, 23,
        24, 25, 26, 27, 28, 29, 30, 31
    };

endpackage

// File: logic/traceBridge_settings.svh
// Width and count macros for the trace bridge
`ifndef TRACE_BRIDGE_SETTINGS_SVH
`define TRACE_BRIDGE_SETTINGS_SVH

////////////////////
// Datapath widths
////////////////////

// Integer data width of the core
`define XLEN 32

// Retirement order counter
`define ORDER_W 64

// Register file addressing
`define REG_ADDR_W 5
`define NUM_REGS 32

// Destination write ports reported per retirement
`define NUM_RD 2

////////////////////
// Interrupt bus
////////////////////

// Full irq bus, only some lines are watched
`define NUM_IRQ 32

`endif
